//--- Makefile
TOOL   = verilator
FLAGS  = --binary --timing
TOP    = tb_mpa_mips_x32
FLIST  = build.f
OBJDIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJDIR)

//--- build.f
+incdir+.
mpa_pkg.sv
mpa_instr_mem.sv
mpa_data_mem.sv
mpa_reg_file.sv
mpa_alu.sv
mpa_decoder.sv
mpa_core_datapath.sv
mpa_debug_port.sv
mpa_mips_x32.sv
tb_mpa_mips_x32.sv

//--- mpa_alu.sv
// ------------------------------
// Integer ALU of the core
// Pure combinational, wraps on overflow
// ------------------------------
`default_nettype none

module mpa_alu (
   input  mpa_pkg::alu_op_t  op,
   input  mpa_pkg::data_t    a,
   input  mpa_pkg::data_t    b,
   output mpa_pkg::data_t    result
);

   always_comb begin
      case (op)
         // ADDU and load address
         mpa_pkg::ALU_ADD: result = a + b;
         // SUBU
         mpa_pkg::ALU_SUB: result = a - b;
         mpa_pkg::ALU_AND: result = a & b;
         mpa_pkg::ALU_OR:  result = a | b;
         mpa_pkg::ALU_XOR: result = a ^ b;
         // Unused encodings
         default:          result = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- mpa_core_datapath.sv
// ------------------------------
// Core datapath around the ALU
// PC, operand select, write-back shaping and register write mux
// ------------------------------
`default_nettype none

`include "mpa_params.svh"

module mpa_core_datapath (
   input  wire                  mem_debug_clk_gate,
   input  wire                  HW_RSTn,
   input  wire                  mem_debug,
   input  mpa_pkg::instr_t      instr,
   input  wire                  reg_we,
   input  wire                  dest_is_rd,
   input  wire                  op_imm,
   input  mpa_pkg::wb_sel_t     wb_sel,
   input  mpa_pkg::data_t       rs_data,
   input  mpa_pkg::data_t       rt_data,
   input  mpa_pkg::data_t       alu_result,
   input  mpa_pkg::data_t       load_data,
   input  wire                  dbg_we,
   input  mpa_pkg::reg_idx_t    dbg_idx,
   input  mpa_pkg::data_t       dbg_wdata,
   output mpa_pkg::pc_t         pc,
   output mpa_pkg::reg_idx_t    rs_idx,
   output mpa_pkg::reg_idx_t    rt_idx,
   output mpa_pkg::data_t       alu_a,
   output mpa_pkg::data_t       alu_b,
   output mpa_pkg::dmem_addr_t  load_addr,
   output logic                 rf_we,
   output mpa_pkg::reg_idx_t    rf_idx,
   output mpa_pkg::data_t       rf_wdata
);

   localparam int IMM_EXT_W = `MPA_DATA_W - 16;

   mpa_pkg::reg_idx_t rd_idx;
   mpa_pkg::data_t    imm_sext;
   mpa_pkg::data_t    wb_data;
   logic              core_we;

   // PC steps one word per instruction and freezes during debug hold
   always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
      if (!HW_RSTn) begin
         pc <= mpa_pkg::pc_t'(`MPA_RESET_PC);
      end else if (!mem_debug) begin
         pc <= pc + mpa_pkg::pc_t'(1);
      end
   end

   // Register fields
   assign rs_idx = instr[25:21];
   assign rt_idx = instr[20:16];
   assign rd_idx = instr[15:11];

   // Offset for loads
   assign imm_sext = {{IMM_EXT_W{instr[15]}}, instr[15:0]};

   // Operand select
   assign alu_a = rs_data;
   assign alu_b = op_imm ? imm_sext : rt_data;

   // Loads address words with the upper sum bits dropped
   assign load_addr = alu_result[`MPA_DMEM_AW-1:0];

   // Write-back word with zero fill for unsigned loads
   always_comb begin
      case (wb_sel)
         mpa_pkg::WB_LUI:  wb_data = {instr[15:0], {IMM_EXT_W{1'b0}}};
         mpa_pkg::WB_BYTE: wb_data = {{(`MPA_DATA_W - 8){1'b0}}, load_data[7:0]};
         mpa_pkg::WB_HALF: wb_data = {{IMM_EXT_W{1'b0}}, load_data[15:0]};
         mpa_pkg::WB_WORD: wb_data = load_data;
         default:          wb_data = alu_result;
      endcase
   end

   // Core writes suppressed while held
   assign core_we = reg_we & ~mem_debug;

   // Debug write takes the port over the core
   assign rf_we    = dbg_we | core_we;
   assign rf_idx   = dbg_we ? dbg_idx : (dest_is_rd ? rd_idx : rt_idx);
   assign rf_wdata = dbg_we ? dbg_wdata : wb_data;

endmodule

`default_nettype wire

//--- mpa_data_mem.sv
// ------------------------------
// Data store, one word per address
// Loaded over the debug port, read by loads and debug read-back
// ------------------------------
`default_nettype none

`include "mpa_params.svh"

module mpa_data_mem (
   input  wire                  mem_debug_clk_gate,
   input  wire                  HW_RSTn,
   input  mpa_pkg::dmem_addr_t  load_addr,
   input  mpa_pkg::dmem_addr_t  dbg_addr,
   input  wire                  we,
   input  mpa_pkg::data_t       wdata,
   output mpa_pkg::data_t       load_data,
   output mpa_pkg::data_t       dbg_rdata
);

   localparam int DEPTH = 1 << `MPA_DMEM_AW;

   mpa_pkg::data_t mem [DEPTH];

   // Only the debug port writes here, no store instructions
   always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
      if (!HW_RSTn) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[dbg_addr] <= wdata;
      end
   end

   // Load port, same cycle as the address
   assign load_data = mem[load_addr];

   // Debug port
   assign dbg_rdata = mem[dbg_addr];

endmodule

`default_nettype wire

//--- mpa_debug_port.sv
// ------------------------------
// Back-door access decode
// Write strobes per store and the dout read-back select
// ------------------------------
`default_nettype none

module mpa_debug_port (
   input  wire                   mem_debug,
   input  mpa_pkg::debug_func_t  debug_func,
   input  wire                   debug_we,
   input  wire                   debug_re,
   input  mpa_pkg::data_t        im_rdata,
   input  mpa_pkg::data_t        dm_rdata,
   input  mpa_pkg::data_t        mr_rdata,
   output logic                  im_we,
   output logic                  dm_we,
   output logic                  mr_we,
   output mpa_pkg::data_t        dout
);

   logic wr_ok;
   logic rd_ok;

   // Access only while the core is held
   assign wr_ok = mem_debug & debug_we;
   assign rd_ok = mem_debug & debug_re;

   // One strobe per store
   assign im_we = wr_ok && (debug_func == mpa_pkg::DBG_IM);
   assign dm_we = wr_ok && (debug_func == mpa_pkg::DBG_DM);
   assign mr_we = wr_ok && (debug_func == mpa_pkg::DBG_MR);

   // Zero unless a read is requested
   always_comb begin
      dout = '0;
      if (rd_ok) begin
         case (debug_func)
            mpa_pkg::DBG_IM: dout = im_rdata;
            mpa_pkg::DBG_DM: dout = dm_rdata;
            mpa_pkg::DBG_MR: dout = mr_rdata;
            default:         dout = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- mpa_decoder.sv
// ------------------------------
// Instruction decoder
// Turns opcode and funct into the datapath controls of one cycle
// ------------------------------
`default_nettype none

`include "mpa_params.svh"

module mpa_decoder (
   input  mpa_pkg::instr_t   instr,
   output logic              reg_we,
   output logic              dest_is_rd,
   output logic              op_imm,
   output mpa_pkg::alu_op_t  alu_op,
   output mpa_pkg::wb_sel_t  wb_sel
);

   logic [5:0] opcode;
   logic [5:0] funct;

   // R and I format fields
   assign opcode = instr[31:26];
   assign funct  = instr[5:0];

   always_comb begin
      // Anything unmatched retires with no write
      reg_we     = 1'b0;
      dest_is_rd = 1'b0;
      op_imm     = 1'b0;
      alu_op     = mpa_pkg::ALU_ADD;
      wb_sel     = mpa_pkg::WB_ALU;

      case (opcode)
         `MPA_OP_SPECIAL: begin
            // Register-register group writes rd
            reg_we     = 1'b1;
            dest_is_rd = 1'b1;
            case (funct)
               `MPA_FN_ADDU: alu_op = mpa_pkg::ALU_ADD;
               `MPA_FN_SUBU: alu_op = mpa_pkg::ALU_SUB;
               `MPA_FN_AND:  alu_op = mpa_pkg::ALU_AND;
               `MPA_FN_OR:   alu_op = mpa_pkg::ALU_OR;
               `MPA_FN_XOR:  alu_op = mpa_pkg::ALU_XOR;
               // Unsupported funct, incl. all-zero word
               default: begin
                  reg_we     = 1'b0;
                  dest_is_rd = 1'b0;
               end
            endcase
         end
         // Immediate into upper half of rt
         `MPA_OP_LUI: begin
            reg_we = 1'b1;
            wb_sel = mpa_pkg::WB_LUI;
         end
         // Loads use rs + offset as the word address
         `MPA_OP_LW: begin
            reg_we = 1'b1;
            op_imm = 1'b1;
            wb_sel = mpa_pkg::WB_WORD;
         end
         `MPA_OP_LBU: begin
            reg_we = 1'b1;
            op_imm = 1'b1;
            wb_sel = mpa_pkg::WB_BYTE;
         end
         `MPA_OP_LHU: begin
            reg_we = 1'b1;
            op_imm = 1'b1;
            wb_sel = mpa_pkg::WB_HALF;
         end
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

//--- mpa_instr_mem.sv
// ------------------------------
// Instruction store, one word per address
// Loaded over the debug port, read for fetch and for debug read-back
// ------------------------------
`default_nettype none

`include "mpa_params.svh"

module mpa_instr_mem (
   input  wire                 mem_debug_clk_gate,
   input  wire                 HW_RSTn,
   input  mpa_pkg::pc_t        fetch_addr,
   input  mpa_pkg::pc_t        dbg_addr,
   input  wire                 we,
   input  mpa_pkg::data_t      wdata,
   output mpa_pkg::instr_t     instr,
   output mpa_pkg::data_t      dbg_rdata
);

   localparam int DEPTH = 1 << `MPA_IMEM_AW;

   mpa_pkg::data_t mem [DEPTH];

   // Cleared on reset so empty slots decode as no-operations
   always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
      if (!HW_RSTn) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[dbg_addr] <= wdata;
      end
   end

   // Fetch port
   assign instr = mem[fetch_addr];

   // Debug port
   assign dbg_rdata = mem[dbg_addr];

endmodule

`default_nettype wire

//--- mpa_mips_x32.sv
// ------------------------------
// Top of the single-cycle MIPS subset core
// Run with mem_debug low, load and inspect through din/dout when high
// ------------------------------
`default_nettype none

`include "mpa_params.svh"

module mpa_mips_x32 (
   input  wire                   HW_RSTn,
   input  wire                   mem_debug_clk_gate,
   input  mpa_pkg::data_t        din,
   input  mpa_pkg::data_t        addr,
   input  mpa_pkg::debug_func_t  debug_func,
   input  wire                   debug_we,
   input  wire                   debug_re,
   input  wire                   mem_debug,
   output mpa_pkg::data_t        dout
);

   // Fetch and decode
   mpa_pkg::pc_t        pc;
   mpa_pkg::instr_t     instr;
   logic                core_reg_we;
   logic                dest_is_rd;
   logic                op_imm;
   mpa_pkg::alu_op_t    alu_op;
   mpa_pkg::wb_sel_t    wb_sel;

   // Register file and ALU
   mpa_pkg::reg_idx_t   rs_idx;
   mpa_pkg::reg_idx_t   rt_idx;
   mpa_pkg::data_t      rs_data;
   mpa_pkg::data_t      rt_data;
   mpa_pkg::data_t      alu_a;
   mpa_pkg::data_t      alu_b;
   mpa_pkg::data_t      alu_result;
   logic                rf_we;
   mpa_pkg::reg_idx_t   rf_idx;
   mpa_pkg::data_t      rf_wdata;

   // Loads
   mpa_pkg::dmem_addr_t load_addr;
   mpa_pkg::data_t      load_data;

   // Debug strobes and read-back
   logic                im_we;
   logic                dm_we;
   logic                mr_we;
   mpa_pkg::data_t      im_rdata;
   mpa_pkg::data_t      dm_rdata;
   mpa_pkg::data_t      mr_rdata;

   mpa_instr_mem u_instr_mem (
      .mem_debug_clk_gate (mem_debug_clk_gate),
      .HW_RSTn            (HW_RSTn),
      .fetch_addr         (pc),
      .dbg_addr           (addr[`MPA_IMEM_AW-1:0]),
      .we                 (im_we),
      .wdata              (din),
      .instr              (instr),
      .dbg_rdata          (im_rdata)
   );

   mpa_data_mem u_data_mem (
      .mem_debug_clk_gate (mem_debug_clk_gate),
      .HW_RSTn            (HW_RSTn),
      .load_addr          (load_addr),
      .dbg_addr           (addr[`MPA_DMEM_AW-1:0]),
      .we                 (dm_we),
      .wdata              (din),
      .load_data          (load_data),
      .dbg_rdata          (dm_rdata)
   );

   mpa_reg_file u_reg_file (
      .mem_debug_clk_gate (mem_debug_clk_gate),
      .HW_RSTn            (HW_RSTn),
      .rs_idx             (rs_idx),
      .rt_idx             (rt_idx),
      .dbg_idx            (addr[`MPA_REG_AW-1:0]),
      .we                 (rf_we),
      .w_idx              (rf_idx),
      .w_data             (rf_wdata),
      .rs_data            (rs_data),
      .rt_data            (rt_data),
      .dbg_data           (mr_rdata)
   );

   mpa_decoder u_decoder (
      .instr      (instr),
      .reg_we     (core_reg_we),
      .dest_is_rd (dest_is_rd),
      .op_imm     (op_imm),
      .alu_op     (alu_op),
      .wb_sel     (wb_sel)
   );

   mpa_alu u_alu (
      .op     (alu_op),
      .a      (alu_a),
      .b      (alu_b),
      .result (alu_result)
   );

   // Debug register writes share the core write port
   mpa_core_datapath u_core_datapath (
      .mem_debug_clk_gate (mem_debug_clk_gate),
      .HW_RSTn            (HW_RSTn),
      .mem_debug          (mem_debug),
      .instr              (instr),
      .reg_we             (core_reg_we),
      .dest_is_rd         (dest_is_rd),
      .op_imm             (op_imm),
      .wb_sel             (wb_sel),
      .rs_data            (rs_data),
      .rt_data            (rt_data),
      .alu_result         (alu_result),
      .load_data          (load_data),
      .dbg_we             (mr_we),
      .dbg_idx            (addr[`MPA_REG_AW-1:0]),
      .dbg_wdata          (din),
      .pc                 (pc),
      .rs_idx             (rs_idx),
      .rt_idx             (rt_idx),
      .alu_a              (alu_a),
      .alu_b              (alu_b),
      .load_addr          (load_addr),
      .rf_we              (rf_we),
      .rf_idx             (rf_idx),
      .rf_wdata           (rf_wdata)
   );

   mpa_debug_port u_debug_port (
      .mem_debug  (mem_debug),
      .debug_func (debug_func),
      .debug_we   (debug_we),
      .debug_re   (debug_re),
      .im_rdata   (im_rdata),
      .dm_rdata   (dm_rdata),
      .mr_rdata   (mr_rdata),
      .im_we      (im_we),
      .dm_we      (dm_we),
      .mr_we      (mr_we),
      .dout       (dout)
   );

endmodule

`default_nettype wire

//--- mpa_params.svh
// ------------------------------
// Shared widths, reset PC and instruction codes of the MIPS core
// Included by the package and by every RTL file that sizes from these
// ------------------------------
`ifndef MPA_PARAMS_SVH
`define MPA_PARAMS_SVH

// Datapath and instruction word width
`define MPA_DATA_W 32

// Word address widths of the two memories
`define MPA_IMEM_AW 8
`define MPA_DMEM_AW 8

// Register index width (32 registers)
`define MPA_REG_AW 5

// PC value after reset, in words
`define MPA_RESET_PC 0

// Primary opcodes, instr[31:26]
`define MPA_OP_SPECIAL 6'h00
`define MPA_OP_LUI 6'h0F
`define MPA_OP_LW 6'h23
`define MPA_OP_LBU 6'h24
`define MPA_OP_LHU 6'h25

// SPECIAL funct codes, instr[5:0]
`define MPA_FN_ADDU 6'h21
`define MPA_FN_SUBU 6'h23
`define MPA_FN_AND 6'h24
`define MPA_FN_OR 6'h25
`define MPA_FN_XOR 6'h26

`endif

//--- mpa_pkg.sv
// ------------------------------
// Common types of the MIPS core
// Vector widths and select encodings shared across the module tree
// ------------------------------
`default_nettype none

`include "mpa_params.svh"

package mpa_pkg;

   // Register and memory word
   typedef logic [`MPA_DATA_W-1:0] data_t;

   // Instruction word as fetched
   typedef logic [`MPA_DATA_W-1:0] instr_t;

   // Instruction memory word address
   typedef logic [`MPA_IMEM_AW-1:0] pc_t;

   // Data memory word address
   typedef logic [`MPA_DMEM_AW-1:0] dmem_addr_t;

   // Register number
   typedef logic [`MPA_REG_AW-1:0] reg_idx_t;

   // ALU function select
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_t;

   // Source of the register write-back word
   typedef enum logic [2:0] {
      WB_ALU,
      WB_LUI,
      WB_BYTE,
      WB_HALF,
      WB_WORD
   } wb_sel_t;

   // Store addressed by the debug port
   typedef enum logic [1:0] {
      DBG_NONE = 2'd0,
      DBG_IM   = 2'd1,
      DBG_DM   = 2'd2,
      DBG_MR   = 2'd3
   } debug_func_t;

endpackage

`default_nettype wire

//--- mpa_reg_file.sv
// ------------------------------
// General purpose registers
// Two reads for the core, one for debug, one shared write port
// ------------------------------
`default_nettype none

`include "mpa_params.svh"

module mpa_reg_file (
   input  wire                mem_debug_clk_gate,
   input  wire                HW_RSTn,
   input  mpa_pkg::reg_idx_t  rs_idx,
   input  mpa_pkg::reg_idx_t  rt_idx,
   input  mpa_pkg::reg_idx_t  dbg_idx,
   input  wire                we,
   input  mpa_pkg::reg_idx_t  w_idx,
   input  mpa_pkg::data_t     w_data,
   output mpa_pkg::data_t     rs_data,
   output mpa_pkg::data_t     rt_data,
   output mpa_pkg::data_t     dbg_data
);

   localparam int NUM_REGS = 1 << `MPA_REG_AW;

   mpa_pkg::data_t regs [NUM_REGS];

   // Register 0 always reads as zero
   function automatic mpa_pkg::data_t read_reg(input mpa_pkg::reg_idx_t idx);
      mpa_pkg::data_t val;
      val = (idx == '0) ? '0 : regs[idx];
      return val;
   endfunction

   // Writes to register 0 dropped
   always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
      if (!HW_RSTn) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (w_idx != '0)) begin
         regs[w_idx] <= w_data;
      end
   end

   // Asynchronous reads
   assign rs_data  = read_reg(rs_idx);
   assign rt_data  = read_reg(rt_idx);
   assign dbg_data = read_reg(dbg_idx);

endmodule

`default_nettype wire

//--- tb_mpa_mips_x32.sv
// ------------------------------
// Self-checking testbench of the MIPS subset core
// Loads programs over the debug port, runs them, compares all registers
// ------------------------------
`default_nettype none

module tb_mpa_mips_x32;

   // Opcodes and functs as the instruction set defines them
   localparam logic [5:0] OP_SPECIAL = 6'h00;
   localparam logic [5:0] OP_LUI = 6'h0F;
   localparam logic [5:0] OP_LW = 6'h23;
   localparam logic [5:0] OP_LBU = 6'h24;
   localparam logic [5:0] OP_LHU = 6'h25;
   localparam logic [5:0] FN_ADDU = 6'h21;
   localparam logic [5:0] FN_SUBU = 6'h23;
   localparam logic [5:0] FN_AND = 6'h24;
   localparam logic [5:0] FN_OR = 6'h25;
   localparam logic [5:0] FN_XOR = 6'h26;
   // Encodings outside the subset
   localparam logic [5:0] OP_ADDI = 6'h08;
   localparam logic [5:0] OP_SW = 6'h2B;
   localparam logic [5:0] FN_ADD = 6'h20;
   localparam logic [5:0] FN_SLL = 6'h00;

   localparam int MEM_WORDS = 256;
   localparam int NUM_REGS = 32;
   localparam int RESET_CYC = 16;
   // Cycle budget per test for program load and run, setup, read-back and hold
   localparam int NUM_TESTS = 5;
   localparam int PROG_MAX = 8;
   localparam int DATA_MAX = 4;
   localparam int REG_INIT_MAX = 8;
   localparam int HOLD_MAX = 8;
   localparam int TEST_CYC = 2 * PROG_MAX + DATA_MAX + REG_INIT_MAX + NUM_REGS + HOLD_MAX;
   localparam int CYCLE_LIMIT = RESET_CYC + NUM_TESTS * TEST_CYC + 64;

   logic                 mem_debug_clk_gate;
   logic                 HW_RSTn;
   mpa_pkg::data_t       din;
   mpa_pkg::data_t       addr;
   mpa_pkg::debug_func_t debug_func;
   logic                 debug_we;
   logic                 debug_re;
   logic                 mem_debug;
   mpa_pkg::data_t       dout;

   // Reference state of memories, registers and PC
   mpa_pkg::data_t m_imem [MEM_WORDS];
   mpa_pkg::data_t m_dmem [MEM_WORDS];
   mpa_pkg::data_t m_regs [NUM_REGS];
   mpa_pkg::data_t prog[$];
   int             m_pc = 0;
   int             seed;
   int             checks = 0;
   int             errors = 0;
   int             test_num = 0;
   int             test_err0 = 0;
   string          test_name;
   int             cycles = 0;

   mpa_mips_x32 u_dut (
      .HW_RSTn            (HW_RSTn),
      .mem_debug_clk_gate (mem_debug_clk_gate),
      .din                (din),
      .addr               (addr),
      .debug_func         (debug_func),
      .debug_we           (debug_we),
      .debug_re           (debug_re),
      .mem_debug          (mem_debug),
      .dout               (dout)
   );

   initial begin
      mem_debug_clk_gate = 1'b0;
      forever #5 mem_debug_clk_gate = ~mem_debug_clk_gate;
   end

   // Watchdog over the whole run
   always @(posedge mem_debug_clk_gate) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic mpa_pkg::data_t enc_r(input logic [5:0] fn, input int rs, input int rt,
                                            input int rd);
      return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
   endfunction

   function automatic mpa_pkg::data_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                            input int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   // Expected effect of one instruction on the model with its write enable as result
   function automatic logic ref_exec(input mpa_pkg::data_t ins, output logic [4:0] dst,
                                     output mpa_pkg::data_t val);
      mpa_pkg::data_t rs_v;
      mpa_pkg::data_t rt_v;
      mpa_pkg::data_t sum;
      logic [7:0]     ea;
      logic           we;
      rs_v = m_regs[ins[25:21]];
      rt_v = m_regs[ins[20:16]];
      // Loads address data words by rs plus sign-extended offset
      sum = rs_v + {{16{ins[15]}}, ins[15:0]};
      ea = sum[7:0];
      dst = ins[20:16];
      val = '0;
      we = 1'b1;
      case (ins[31:26])
         OP_SPECIAL: begin
            dst = ins[15:11];
            case (ins[5:0])
               FN_ADDU: val = rs_v + rt_v;
               FN_SUBU: val = rs_v - rt_v;
               FN_AND:  val = rs_v & rt_v;
               FN_OR:   val = rs_v | rt_v;
               FN_XOR:  val = rs_v ^ rt_v;
               default: we = 1'b0;
            endcase
         end
         OP_LUI: val = {ins[15:0], 16'h0000};
         OP_LW:  val = m_dmem[ea];
         OP_LBU: val = {24'h000000, m_dmem[ea][7:0]};
         OP_LHU: val = {16'h0000, m_dmem[ea][15:0]};
         default: we = 1'b0;
      endcase
      return we;
   endfunction

   task automatic check(input string name, input mpa_pkg::data_t got,
                        input mpa_pkg::data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s: got %08h expected %08h", name, got, exp);
      end
   endtask

   // Each access below starts just after a rising edge and lasts one cycle
   task automatic dbg_write(input mpa_pkg::debug_func_t func, input mpa_pkg::data_t a,
                            input mpa_pkg::data_t d);
      mem_debug  <= 1'b1;
      debug_func <= func;
      addr       <= a;
      din        <= d;
      debug_we   <= 1'b1;
      debug_re   <= 1'b0;
      @(posedge mem_debug_clk_gate);
   endtask

   task automatic expect_read(input mpa_pkg::debug_func_t func, input int a, input logic re,
                              input mpa_pkg::data_t exp);
      mem_debug  <= 1'b1;
      debug_func <= func;
      addr       <= a;
      din        <= '0;
      debug_we   <= 1'b0;
      debug_re   <= re;
      // dout settles before the falling edge
      @(negedge mem_debug_clk_gate);
      check($sformatf("dout (func %0d addr %0h re %0b)", func, a, re), dout, exp);
      @(posedge mem_debug_clk_gate);
   endtask

   task automatic load_data(input int a, input mpa_pkg::data_t d);
      dbg_write(mpa_pkg::DBG_DM, a, d);
      m_dmem[a[7:0]] = d;
   endtask

   task automatic set_reg(input int r, input mpa_pkg::data_t d);
      dbg_write(mpa_pkg::DBG_MR, r, d);
      if (r[4:0] != 5'd0) begin
         m_regs[r[4:0]] = d;
      end
   endtask

   // Program is placed at the current PC as the PC only moves while running
   task automatic load_prog();
      for (int i = 0; i < prog.size(); i++) begin
         dbg_write(mpa_pkg::DBG_IM, (m_pc + i) % MEM_WORDS, prog[i]);
         m_imem[(m_pc + i) % MEM_WORDS] = prog[i];
      end
   endtask

   // One instruction per cycle while mem_debug is low
   task automatic run_prog(input int n);
      logic [4:0]     dst;
      mpa_pkg::data_t val;
      mem_debug <= 1'b0;
      debug_we  <= 1'b0;
      debug_re  <= 1'b0;
      repeat (n) @(posedge mem_debug_clk_gate);
      mem_debug <= 1'b1;
      for (int i = 0; i < n; i++) begin
         if (ref_exec(m_imem[m_pc[7:0]], dst, val) && (dst != 5'd0)) begin
            m_regs[dst] = val;
         end
         m_pc = (m_pc + 1) % MEM_WORDS;
      end
   endtask

   task automatic compare_regs();
      for (int r = 0; r < NUM_REGS; r++) begin
         expect_read(mpa_pkg::DBG_MR, r, 1'b1, m_regs[r[4:0]]);
      end
   endtask

   task automatic test_begin(input string name);
      test_num++;
      test_name = name;
      test_err0 = errors;
      prog.delete();
   endtask

   task automatic test_end();
      $display("Test %0d %s: %0d errors", test_num, test_name, errors - test_err0);
   endtask

   initial begin
      seed = 32'hffc6_2483;
      HW_RSTn    <= 1'b0;
      mem_debug  <= 1'b1;
      din        <= '0;
      addr       <= '0;
      debug_func <= mpa_pkg::DBG_NONE;
      debug_we   <= 1'b0;
      debug_re   <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         m_imem[i[7:0]] = '0;
         m_dmem[i[7:0]] = '0;
      end
      for (int i = 0; i < NUM_REGS; i++) begin
         m_regs[i[4:0]] = '0;
      end
      repeat (RESET_CYC) @(posedge mem_debug_clk_gate);
      HW_RSTn <= 1'b1;
      @(posedge mem_debug_clk_gate);

      // Cleared state and then write and read back of each store
      test_begin("reset and debug access");
      expect_read(mpa_pkg::DBG_MR, 1, 1'b0, '0);
      expect_read(mpa_pkg::DBG_MR, 1, 1'b1, '0);
      expect_read(mpa_pkg::DBG_MR, 31, 1'b1, '0);
      expect_read(mpa_pkg::DBG_DM, 17, 1'b1, '0);
      expect_read(mpa_pkg::DBG_DM, 255, 1'b1, '0);
      expect_read(mpa_pkg::DBG_IM, 3, 1'b1, '0);
      // Slot 200 is far past any program
      dbg_write(mpa_pkg::DBG_IM, 200, $random(seed));
      m_imem[200] = 32'h1234_5678;
      dbg_write(mpa_pkg::DBG_IM, 200, m_imem[200]);
      expect_read(mpa_pkg::DBG_IM, 200, 1'b1, m_imem[200]);
      load_data(10, $random(seed));
      expect_read(mpa_pkg::DBG_DM, 10, 1'b1, m_dmem[10]);
      set_reg(7, $random(seed));
      expect_read(mpa_pkg::DBG_MR, 7, 1'b1, m_regs[7]);
      set_reg(0, $random(seed));
      expect_read(mpa_pkg::DBG_MR, 0, 1'b1, '0);
      expect_read(mpa_pkg::DBG_MR, 7, 1'b0, '0);
      test_end();

      test_begin("LUI and LW");
      set_reg(3, 20);
      set_reg(4, 40);
      load_data(24, $random(seed));
      load_data(32, $random(seed));
      load_data(19, $random(seed));
      prog.push_back(enc_i(OP_LUI, 0, 1, $random(seed)));
      prog.push_back(enc_i(OP_LUI, 5, 2, 'h8001));
      prog.push_back(enc_i(OP_LW, 3, 5, 4));
      prog.push_back(enc_i(OP_LW, 4, 6, 'hfff8));
      prog.push_back(enc_i(OP_LW, 3, 7, 'hffff));
      prog.push_back(enc_i(OP_LW, 0, 8, 24));
      load_prog();
      run_prog(prog.size());
      compare_regs();
      test_end();

      test_begin("LBU and LHU");
      set_reg(10, 40);
      for (int i = 0; i < DATA_MAX; i++) begin
         load_data(40 + i, $random(seed) | 32'hf0f0_8080);
      end
      prog.push_back(enc_i(OP_LBU, 10, 11, 0));
      prog.push_back(enc_i(OP_LHU, 10, 12, 1));
      prog.push_back(enc_i(OP_LBU, 10, 13, 2));
      prog.push_back(enc_i(OP_LHU, 10, 14, 3));
      load_prog();
      run_prog(prog.size());
      compare_regs();
      test_end();

      test_begin("register ALU group");
      for (int r = 16; r < 20; r++) begin
         set_reg(r, $random(seed));
      end
      set_reg(20, 32'hffff_ffff);
      set_reg(21, 1);
      set_reg(22, 0);
      // First two wrap around
      prog.push_back(enc_r(FN_ADDU, 20, 21, 23));
      prog.push_back(enc_r(FN_SUBU, 22, 21, 24));
      prog.push_back(enc_r(FN_ADDU, 16, 17, 25));
      prog.push_back(enc_r(FN_SUBU, 17, 18, 26));
      prog.push_back(enc_r(FN_AND, 16, 19, 27));
      prog.push_back(enc_r(FN_OR, 17, 19, 28));
      prog.push_back(enc_r(FN_XOR, 18, 16, 29));
      prog.push_back(enc_r(FN_XOR, 16, 17, 0));
      load_prog();
      run_prog(prog.size());
      compare_regs();
      test_end();

      test_begin("no-ops and hold");
      set_reg(21, 1);
      set_reg(30, $random(seed));
      prog.push_back(enc_i(OP_ADDI, 30, 1, 5));
      prog.push_back(enc_r(FN_ADD, 16, 17, 2));
      prog.push_back(enc_r(FN_SLL, 0, 16, 3));
      prog.push_back(enc_i(OP_SW, 10, 4, 0));
      prog.push_back(32'h0000_0000);
      // Count of increments shows a skipped or repeated step
      prog.push_back(enc_r(FN_ADDU, 30, 21, 30));
      prog.push_back(enc_r(FN_ADDU, 30, 21, 30));
      prog.push_back(enc_r(FN_ADDU, 30, 21, 30));
      load_prog();
      run_prog(6);
      expect_read(mpa_pkg::DBG_MR, 30, 1'b1, m_regs[30]);
      expect_read(mpa_pkg::DBG_MR, 2, 1'b1, m_regs[2]);
      expect_read(mpa_pkg::DBG_MR, 30, 1'b1, m_regs[30]);
      run_prog(2);
      compare_regs();
      test_end();

      $display("Tests %0d, checks %0d, errors %0d", test_num, checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
